//--- conv_pad_macros.svh
/* project-wide sizes, field widths and side-band bit positions for the padding path
   include wherever a size or a side-band bit is needed */
`ifndef CONV_PAD_MACROS_SVH
`define CONV_PAD_MACROS_SVH

// kernel and stride limits
`define KW_MAX          7
`define KW2_MAX         (`KW_MAX / 2)
`define SW_MAX          2
`define MEMBERS         12

// field widths
`define BITS_KW         3
`define BITS_KW2        2
`define BITS_SW         1
`define BITS_MEMBERS    4
`define BITS_OUT_SHIFT  4
`define BITS_COLS       8
`define BITS_CIN        6

// side-band word layout, kw2 takes bits 5:4
`define TUSER_WIDTH     7
`define I_IS_CONFIG     0
`define I_IS_CIN_LAST   1
`define I_IS_COL_VALID  2
`define I_IS_COLS_1_K2  3
`define I_KW2           4
`define I_SW_1          6

// kernel k and stride s pairs that get lookup entries
`define KS_COMBS_EXPR   (k > s)

`endif

//--- conv_pad_pkg.sv
/* shared types of the padding path, imported by every module that uses them */
`default_nettype none

`include "conv_pad_macros.svh"

package conv_pad_pkg;

    // side-band word that travels with each beat
    typedef logic [`TUSER_WIDTH-1:0]    tuser_t;

    // configuration fields
    typedef logic [`BITS_KW2-1:0]       kw2_t;
    typedef logic [`BITS_SW-1:0]        sw_t;

    // 0 center, odd values left, even values right
    typedef logic [`BITS_KW-1:0]        clr_code_t;

    // output shifts
    typedef logic [`BITS_MEMBERS-1:0]   shift_a_t;
    typedef logic [`BITS_OUT_SHIFT-1:0] shift_b_t;

    // beat counters
    typedef logic [`BITS_COLS-1:0]      cols_t;
    typedef logic [`BITS_CIN-1:0]       cin_t;

    // input sequencer
    typedef enum logic [1:0] {SEQ_IDLE, SEQ_CONFIG, SEQ_RUN} seq_state_t;

endpackage

`default_nettype wire

//--- conv_tuser_gen.sv
/* input side sequencer; on start it sends one config beat and then one row of
   column by channel beats, each with its side-band word */
`default_nettype none

`include "conv_pad_macros.svh"

module conv_tuser_gen
    import conv_pad_pkg::*;
(
    input  wire        aclk,
    input  wire        aclken,
    input  wire        reset,
    input  wire        start,
    input  wire kw2_t  kw2,
    input  wire sw_t   sw_1,
    input  wire cols_t cols_1,
    input  wire cin_t  cin_1,
    output logic       valid_in,
    output tuser_t     user_in
);

    seq_state_t state;

    // configuration held for the whole row
    kw2_t  kw2_q;
    sw_t   sw_1_q;
    cols_t cols_1_q;
    cin_t  cin_1_q;

    // counters of the beat now on user_in
    cols_t col_cnt;
    cin_t  cin_cnt;

    cols_t  nxt_col;
    cin_t   nxt_cin;
    cols_t  col_mark;
    logic   row_done;
    tuser_t cfg_word;
    tuser_t run_word;

    function automatic tuser_t make_word(input logic cfg, input logic cin_last,
                                         input logic col_valid, input logic mark,
                                         input kw2_t k2, input sw_t s1);
        tuser_t w;
        w = '0;
        w[`I_IS_CONFIG]    = cfg;
        w[`I_IS_CIN_LAST]  = cin_last;
        w[`I_IS_COL_VALID] = col_valid;
        w[`I_IS_COLS_1_K2] = mark;
        w[`I_KW2 +: `BITS_KW2] = k2;
        w[`I_SW_1 +: `BITS_SW] = s1;
        return w;
    endfunction

    // channel index runs fastest, first run beat starts at zero
    always_comb begin
        if (state == SEQ_CONFIG) begin
            nxt_col = '0;
            nxt_cin = '0;
        end else if (cin_cnt == cin_1_q) begin
            nxt_col = cols_t'(col_cnt + 1'b1);
            nxt_cin = '0;
        end else begin
            nxt_col = col_cnt;
            nxt_cin = cin_t'(cin_cnt + 1'b1);
        end
    end

    // marker column sits kw2 columns before the last one
    assign col_mark = cols_t'(cols_1_q - cols_t'(kw2_q));
    assign row_done = (col_cnt == cols_1_q) && (cin_cnt == cin_1_q);

    // config word uses the live inputs, they are latched in the same cycle
    assign cfg_word = make_word(1'b1, 1'b0, 1'b0, 1'b0, kw2, sw_1);
    assign run_word = make_word(1'b0, nxt_cin == cin_1_q, 1'b1, nxt_col == col_mark,
                                kw2_q, sw_1_q);

    always_ff @(posedge aclk) begin
        if (reset) begin
            state    <= SEQ_IDLE;
            valid_in <= 1'b0;
            user_in  <= '0;
            col_cnt  <= '0;
            cin_cnt  <= '0;
        end else if (aclken) begin
            case (state)
                SEQ_RUN: begin
                    if (!row_done) begin
                        col_cnt  <= nxt_col;
                        cin_cnt  <= nxt_cin;
                        user_in  <= run_word;
                    end else if (start) begin
                        // new row straight after the last beat
                        valid_in <= 1'b1;
                        user_in  <= cfg_word;
                        state    <= SEQ_CONFIG;
                    end else begin
                        valid_in <= 1'b0;
                        user_in  <= '0;
                        state    <= SEQ_IDLE;
                    end
                end
                SEQ_CONFIG: begin
                    valid_in <= 1'b1;
                    col_cnt  <= nxt_col;
                    cin_cnt  <= nxt_cin;
                    user_in  <= run_word;
                    state    <= SEQ_RUN;
                end
                default: begin
                    if (start) begin
                        valid_in <= 1'b1;
                        user_in  <= cfg_word;
                        state    <= SEQ_CONFIG;
                    end
                end
            endcase
        end
    end

    // config latch, only taken when a config beat is issued
    always_ff @(posedge aclk) begin
        if (aclken && start && (state == SEQ_IDLE || (state == SEQ_RUN && row_done))) begin
            kw2_q    <= kw2;
            sw_1_q   <= sw_1;
            cols_1_q <= cols_1;
            cin_1_q  <= cin_1;
        end
    end

endmodule

`default_nettype wire

//--- pad_filter.sv
/* padding filter; turns the side-band flags of each beat into per member clr codes,
   a valid mask and the two output shift amounts */
`default_nettype none

`include "conv_pad_macros.svh"

module pad_filter
    import conv_pad_pkg::*;
(
    input  wire                           aclk,
    input  wire                           aclken,
    input  wire                           reset,
    input  wire                           valid_in,
    input  wire tuser_t                   user_in,
    output logic                          valid_mask,
    output clr_code_t [`MEMBERS-1:0]      clr,
    output shift_a_t                      shift_a,
    output shift_b_t                      shift_b
);

    localparam int KW2_MAX = `KW2_MAX;
    localparam int SW_MAX  = `SW_MAX;
    localparam int MEMBERS = `MEMBERS;

    kw2_t kw2_w;
    sw_t  sw_1_w;
    logic is_config;
    logic is_cin_last;
    logic is_col_valid;
    logic is_cols_1_k2;
    logic reg_en;

    // bit j of col_end set during column cols_1-kw2+j
    logic [KW2_MAX:1] col_end_in;
    logic [KW2_MAX:1] col_end_q;
    logic [KW2_MAX:0] col_end;
    // bit j of col_start set during column j-1
    logic [KW2_MAX:1] col_start_in;
    logic [KW2_MAX:1] col_start;

    clr_code_t clr_left_in;
    clr_code_t clr_left;
    logic      start_hit;

    shift_b_t [KW2_MAX:0][SW_MAX-1:0] lut_shift_b;

    // fields of the current beat
    assign kw2_w        = user_in[`I_KW2 +: `BITS_KW2];
    assign sw_1_w       = user_in[`I_SW_1 +: `BITS_SW];
    assign is_config    = user_in[`I_IS_CONFIG];
    assign is_cin_last  = user_in[`I_IS_CIN_LAST];
    assign is_col_valid = user_in[`I_IS_COL_VALID];
    assign is_cols_1_k2 = user_in[`I_IS_COLS_1_K2];

    // registers step once per column and once on config
    assign reg_en = aclken && valid_in && (is_cin_last || is_config);

    // config clears both chains and bits above kw2 are dropped
    assign col_end_in[1]   = !is_config && is_cols_1_k2 && (kw2_w != 0);
    assign col_start_in[1] = is_config ? (kw2_w != 0) : col_end[kw2_w];

    for (genvar k = 2; k <= KW2_MAX; k++) begin : g_chain
        assign col_end_in[k]   = !is_config && col_end_q[k-1] && (kw2_w >= k);
        assign col_start_in[k] = !is_config && col_start[k-1] && (kw2_w >= k);
    end

    // index 0 stands for kw = 1 which has no end column
    assign col_end = {col_end_q, 1'b0};

    // left code 2*(kw2-c)-1 of the next column with c = j-1
    always_comb begin
        clr_left_in = '0;
        for (int j = 1; j <= KW2_MAX; j++) begin
            if (col_start_in[j])
                clr_left_in = clr_code_t'(2 * int'(kw2_w) - 2 * j + 1);
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            col_end_q <= '0;
            col_start <= '0;
            clr_left  <= '0;
        end else if (reg_en) begin
            col_end_q <= col_end_in;
            col_start <= col_start_in;
            clr_left  <= clr_left_in;
        end
    end

    // right codes only on the member before the last of each kernel group
    for (genvar m = 0; m < MEMBERS; m++) begin : g_member
        logic [KW2_MAX:0] last_member;
        logic [KW2_MAX:1] col_end_m;
        clr_code_t        clr_right;

        assign last_member[0] = 1'b0;
        for (genvar k2 = 1; k2 <= KW2_MAX; k2++) begin : g_kw
            assign last_member[k2] = (m % (2 * k2 + 1)) == (2 * k2 - 1);
        end

        // non selected members load zero so an old kernel leaves nothing behind
        always_ff @(posedge aclk) begin
            if (reset)
                col_end_m <= '0;
            else if (reg_en)
                col_end_m <= last_member[kw2_w] ? col_end_in : '0;
        end

        // 2*j for the set end bit
        always_comb begin
            clr_right = '0;
            for (int j = 1; j <= KW2_MAX; j++) begin
                if (col_end_m[j])
                    clr_right = clr_code_t'(2 * j);
            end
        end

        assign clr[m] = clr_left | clr_right;
    end

    // first kw2 columns of a row are masked
    always_comb begin
        start_hit = 1'b0;
        for (int j = 1; j <= KW2_MAX; j++) begin
            if (col_start[j] && (j <= int'(kw2_w)))
                start_hit = 1'b1;
        end
    end

    assign valid_mask = (is_col_valid && !start_hit) || is_config;

    // shift_a carries kw2 only on the last column of the row
    assign shift_a = col_end[kw2_w] ? shift_a_t'(kw2_w) : '0;

    // shift_b table with one entry per kernel and stride
    for (genvar k2 = 0; k2 <= KW2_MAX; k2++) begin : g_shift_kw
        for (genvar s1 = 0; s1 < SW_MAX; s1++) begin : g_shift_sw
            localparam int k = 2 * k2 + 1;
            localparam int s = s1 + 1;
            localparam int j = k + s - 1;

            if (k2 != 0 && `KS_COMBS_EXPR) begin : g_entry
                assign lut_shift_b[k2][s1] = shift_b_t'(MEMBERS / j - 1);
            end else begin : g_none
                assign lut_shift_b[k2][s1] = '0;
            end
        end
    end

    assign shift_b = lut_shift_b[kw2_w][sw_1_w];

endmodule

`default_nettype wire

//--- pad_out_stage.sv
/* registered output boundary; carries the filter results one cycle on
   with a beat-valid flag */
`default_nettype none

`include "conv_pad_macros.svh"

module pad_out_stage
    import conv_pad_pkg::*;
(
    input  wire                           aclk,
    input  wire                           aclken,
    input  wire                           reset,
    input  wire                           valid_in,
    input  wire                           valid_mask,
    input  wire clr_code_t [`MEMBERS-1:0] clr,
    input  wire shift_a_t                 shift_a,
    input  wire shift_b_t                 shift_b,
    output logic                          out_valid,
    output logic                          out_mask,
    output clr_code_t [`MEMBERS-1:0]      out_clr,
    output shift_a_t                      out_shift_a,
    output shift_b_t                      out_shift_b
);

    // beat flag and mask
    always_ff @(posedge aclk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_mask  <= 1'b0;
        end else if (aclken) begin
            out_valid <= valid_in;
            // mask qualified by the beat
            out_mask  <= valid_in && valid_mask;
        end
    end

    // results of the same beat
    always_ff @(posedge aclk) begin
        if (reset) begin
            out_clr     <= '0;
            out_shift_a <= '0;
            out_shift_b <= '0;
        end else if (aclken) begin
            out_clr     <= clr;
            out_shift_a <= shift_a;
            out_shift_b <= shift_b;
        end
    end

endmodule

`default_nettype wire

//--- conv_pad_top.sv
/* top of the padding control path; sequencer, filter and output stage
   chained one stage each */
`default_nettype none

`include "conv_pad_macros.svh"

module conv_pad_top
    import conv_pad_pkg::*;
(
    input  wire                      aclk,
    input  wire                      aclken,
    input  wire                      reset,
    input  wire                      start,
    input  wire kw2_t                kw2,
    input  wire sw_t                 sw_1,
    input  wire cols_t               cols_1,
    input  wire cin_t                cin_1,
    output logic                     out_valid,
    output logic                     out_mask,
    output clr_code_t [`MEMBERS-1:0] out_clr,
    output shift_a_t                 out_shift_a,
    output shift_b_t                 out_shift_b
);

    // beat stream into the filter
    logic   valid_in;
    tuser_t user_in;

    // filter results
    logic                      valid_mask;
    clr_code_t [`MEMBERS-1:0]  clr;
    shift_a_t                  shift_a;
    shift_b_t                  shift_b;

    conv_tuser_gen u_tuser_gen (
        .aclk     (aclk),
        .aclken   (aclken),
        .reset    (reset),
        .start    (start),
        .kw2      (kw2),
        .sw_1     (sw_1),
        .cols_1   (cols_1),
        .cin_1    (cin_1),
        .valid_in (valid_in),
        .user_in  (user_in)
    );

    pad_filter u_pad_filter (
        .aclk       (aclk),
        .aclken     (aclken),
        .reset      (reset),
        .valid_in   (valid_in),
        .user_in    (user_in),
        .valid_mask (valid_mask),
        .clr        (clr),
        .shift_a    (shift_a),
        .shift_b    (shift_b)
    );

    pad_out_stage u_out_stage (
        .aclk        (aclk),
        .aclken      (aclken),
        .reset       (reset),
        .valid_in    (valid_in),
        .valid_mask  (valid_mask),
        .clr         (clr),
        .shift_a     (shift_a),
        .shift_b     (shift_b),
        .out_valid   (out_valid),
        .out_mask    (out_mask),
        .out_clr     (out_clr),
        .out_shift_a (out_shift_a),
        .out_shift_b (out_shift_b)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/* free running testbench clock, period 40 */
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 20;

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

//--- conv_pad_sva.sv
/* output checks of the padding path, attached to the top level by the bind at the end
   of this file */
`default_nettype none

`include "conv_pad_macros.svh"

module conv_pad_sva
    import conv_pad_pkg::*;
(
    input wire           aclk,
    input wire           aclken,
    input wire           reset,
    input wire           valid_in,
    input wire tuser_t   user_in,
    input wire           out_valid,
    input wire           out_mask,
    input wire shift_b_t out_shift_b
);

    // number of failed assertions
    int unsigned fail_count = 0;

    // the beat now on the outputs is a config beat
    logic out_is_cfg;

    always_ff @(posedge aclk) begin
        if (reset)
            out_is_cfg <= 1'b0;
        else if (aclken)
            out_is_cfg <= valid_in && user_in[`I_IS_CONFIG];
    end

    // outputs come out of reset cleared
    a_reset_clear: assert property (@(posedge aclk) reset |=> !out_valid && !out_mask)
    else begin
        fail_count++;
        $error("out_valid or out_mask high in the cycle after reset");
    end

    // mask only rides on a beat
    a_mask_valid: assert property (@(posedge aclk) disable iff (reset)
        out_mask |-> out_valid)
    else begin
        fail_count++;
        $error("out_mask high without out_valid");
    end

    // one shift_b per configuration, a config beat may change it
    a_shift_b_steady: assert property (@(posedge aclk) disable iff (reset)
        (out_valid && $past(out_valid) && !out_is_cfg) |-> $stable(out_shift_b))
    else begin
        fail_count++;
        $error("out_shift_b changed inside a row");
    end

endmodule

bind conv_pad_top conv_pad_sva u_sva (
    .aclk        (aclk),
    .aclken      (aclken),
    .reset       (reset),
    .valid_in    (valid_in),
    .user_in     (user_in),
    .out_valid   (out_valid),
    .out_mask    (out_mask),
    .out_shift_b (out_shift_b)
);

`default_nettype wire

//--- conv_pad_tb.sv
/* testbench of the padding path; runs fixed and random rows, compares every output beat
   with a model of the padding rules and prints the result line */
`default_nettype none

`include "conv_pad_macros.svh"

module conv_pad_tb
    import conv_pad_pkg::*;
();

    localparam int DRIVE_DLY = 2;
    localparam int CHECK_DLY = 1;
    localparam int MEMBERS   = `MEMBERS;
    localparam int NFIXED    = 8;
    localparam int NCFG      = 14;

    // fixed rows cover kw 3 5 7 with both strides and end in a back to back chain through kw 1
    localparam int FIXED_KW2 [NFIXED] = '{1, 2, 3, 1, 2, 3, 0, 2};
    localparam int FIXED_SW1 [NFIXED] = '{0, 0, 0, 1, 1, 1, 0, 0};
    localparam int FIXED_B2B [NFIXED] = '{0, 0, 0, 0, 0, 1, 1, 1};

    typedef struct packed {
        logic  cfg;
        kw2_t  kw2;
        sw_t   sw_1;
        cols_t cols_1;
        cols_t col;
    } beat_t;

    logic  aclk;
    logic  aclken;
    logic  reset;
    logic  start;
    kw2_t  kw2;
    sw_t   sw_1;
    cols_t cols_1;
    cin_t  cin_1;
    logic  out_valid;
    logic  out_mask;
    clr_code_t [MEMBERS-1:0] out_clr;
    shift_a_t out_shift_a;
    shift_b_t out_shift_b;

    int cfg_kw2 [NCFG];
    int cfg_sw1 [NCFG];
    int cfg_cols1 [NCFG];
    int cfg_cin1 [NCFG];
    int cfg_b2b [NCFG];
    int cfg_gaps [NCFG];

    beat_t       exp_q [$];
    beat_t       cur_beat;
    logic [31:0] lfsr;
    logic        gaps_on;
    logic        gaps_now;
    logic        first_start;
    logic        en_edge;
    int          errors;
    int          sva_fails;
    int          total_beats;
    int          cycle_cnt;
    int          cycle_limit;

    tb_clock_gen u_clock_gen (.clk(aclk));

    conv_pad_top uut (
        .aclk        (aclk),
        .aclken      (aclken),
        .reset       (reset),
        .start       (start),
        .kw2         (kw2),
        .sw_1        (sw_1),
        .cols_1      (cols_1),
        .cin_1       (cin_1),
        .out_valid   (out_valid),
        .out_mask    (out_mask),
        .out_clr     (out_clr),
        .out_shift_a (out_shift_a),
        .out_shift_b (out_shift_b)
    );

    // one galois lfsr step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] x);
        return x[0] ? ((x >> 1) ^ 32'h8020_0003) : (x >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic build_configs();
        total_beats = 0;
        for (int i = 0; i < NCFG; i++) begin
            if (i < NFIXED) begin
                cfg_kw2[i]   = FIXED_KW2[i];
                cfg_sw1[i]   = FIXED_SW1[i];
                cfg_cols1[i] = 9;
                cfg_cin1[i]  = 2;
                cfg_b2b[i]   = FIXED_B2B[i];
                cfg_gaps[i]  = 0;
            end else begin
                // random rows keep the width at 2*kw2+1 or more
                cfg_kw2[i]   = take_bits(2);
                cfg_sw1[i]   = take_bits(1);
                cfg_cols1[i] = 6 + take_bits(3);
                cfg_cin1[i]  = take_bits(2);
                cfg_b2b[i]   = take_bits(1);
                cfg_gaps[i]  = 1;
            end
            total_beats += 1 + (cfg_cols1[i] + 1) * (cfg_cin1[i] + 1);
        end
        cycle_limit = 2 * total_beats;
    endtask

    // waits for the next rising edge with aclken high and steps past it
    task automatic wait_enabled_edge();
        do begin
            @(posedge aclk);
        end while (!aclken);
        #DRIVE_DLY;
    endtask

    // config beat first and then the run beats with the channel fastest
    task automatic queue_row(input int i);
        beat_t b;
        b.cfg    = 1'b1;
        b.kw2    = kw2_t'(cfg_kw2[i]);
        b.sw_1   = sw_t'(cfg_sw1[i]);
        b.cols_1 = cols_t'(cfg_cols1[i]);
        b.col    = '0;
        exp_q.push_back(b);
        b.cfg = 1'b0;
        for (int c = 0; c <= cfg_cols1[i]; c++) begin
            for (int ch = 0; ch <= cfg_cin1[i]; ch++) begin
                b.col = cols_t'(c);
                exp_q.push_back(b);
            end
        end
    endtask

    task automatic compare_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_beat(input beat_t b);
        int   kw;
        int   k2;
        int   c;
        int   last;
        int   left;
        int   right;
        int   exp_sa;
        int   exp_sb;
        logic exp_mask;
        k2 = int'(b.kw2);
        c = int'(b.col);
        last = int'(b.cols_1);
        kw = 2 * k2 + 1;
        // R1, R2 and R5
        exp_mask = b.cfg || (k2 == 0) || (c >= k2);
        exp_sb = (k2 == 0) ? 0 : MEMBERS / (kw + int'(b.sw_1)) - 1;
        exp_sa = (!b.cfg && c == last) ? k2 : 0;
        compare_value("out_mask", int'(out_mask), int'(exp_mask));
        compare_value("out_shift_a", int'(out_shift_a), exp_sa);
        compare_value("out_shift_b", int'(out_shift_b), exp_sb);
        // R3 and R4 on run beats only since a config beat still shows the previous row
        if (!b.cfg) begin
            for (int m = 0; m < MEMBERS; m++) begin
                left = (c < k2) ? 2 * (k2 - c) - 1 : 0;
                right = ((c > last - k2) && (m % kw == kw - 2)) ? 2 * (k2 - (last - c)) : 0;
                compare_value($sformatf("out_clr[%0d]", m), int'(out_clr[m]), left | right);
            end
        end
    endtask

    // random enable drops in about one cycle of four
    always begin
        @(posedge aclk);
        gaps_now = gaps_on;
        #DRIVE_DLY;
        if (gaps_now)
            aclken = (take_bits(2) != 3);
        else
            aclken = 1'b1;
    end

    // one expected beat per enabled edge with out_valid
    always begin
        @(posedge aclk);
        en_edge = aclken;
        #CHECK_DLY;
        if (!reset) begin
            if (!first_start) begin
                assert (!out_valid && !out_mask && out_clr == '0) else begin
                    $display("reset state not held before the first start at time %0t", $time);
                    errors++;
                end
            end
            if (en_edge && out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected output beat at time %0t", $time);
                    errors++;
                end else begin
                    cur_beat = exp_q.pop_front();
                    check_beat(cur_beat);
                end
            end
        end
    end

    always @(posedge aclk) begin
        if (!reset) begin
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("timeout after %0d cycles with %0d beats outstanding",
                         cycle_limit, exp_q.size());
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    end

    initial begin
        int n;
        reset       = 1'b1;
        aclken      = 1'b1;
        start       = 1'b0;
        kw2         = '0;
        sw_1        = '0;
        cols_1      = '0;
        cin_1       = '0;
        gaps_on     = 1'b0;
        first_start = 1'b0;
        errors      = 0;
        cycle_cnt   = 0;
        lfsr        = 32'hf3ab_c39c;
        build_configs();
        repeat (10) @(posedge aclk);
        #DRIVE_DLY;
        reset = 1'b0;
        // idle stretch where the reset state must hold
        repeat (4) @(posedge aclk);
        #DRIVE_DLY;
        for (int i = 0; i < NCFG; i++) begin
            if (i == 0 || cfg_b2b[i] == 0) begin
                repeat (2) @(posedge aclk);
                #DRIVE_DLY;
            end
            gaps_on = (cfg_gaps[i] != 0);
            kw2     = kw2_t'(cfg_kw2[i]);
            sw_1    = sw_t'(cfg_sw1[i]);
            cols_1  = cols_t'(cfg_cols1[i]);
            cin_1   = cin_t'(cfg_cin1[i]);
            start   = 1'b1;
            wait_enabled_edge();
            start       = 1'b0;
            first_start = 1'b1;
            queue_row(i);
            // last run beat is then on the filter input
            n = (cfg_cols1[i] + 1) * (cfg_cin1[i] + 1);
            repeat (n) wait_enabled_edge();
            // without a chained start the sequencer drops back to idle
            if (i == NCFG - 1 || cfg_b2b[i + 1] == 0)
                wait_enabled_edge();
        end
        while (exp_q.size() != 0) @(posedge aclk);
        repeat (3) @(posedge aclk);
        #DRIVE_DLY;
        sva_fails = uut.u_sva.fail_count;
        $display("end of run: %0d check errors, %0d assertion failures", errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_pad.f
+incdir+.
conv_pad_pkg.sv
conv_tuser_gen.sv
pad_filter.sv
pad_out_stage.sv
conv_pad_top.sv
tb_clock_gen.sv
conv_pad_sva.sv
conv_pad_tb.sv

//--- Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := conv_pad_tb
RTL_TOP    := conv_pad_top
FILELIST   := conv_pad.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
